//--- rtl/issue_macros.svh
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// ----------------------------------------------------------
// Datapath sizes
// ----------------------------------------------------------

// Integer data width
`define XLEN 32
// Architectural registers, register 0 reads as zero
`define NR_REGS 32

// ----------------------------------------------------------
// Scoreboard and pipeline
// ----------------------------------------------------------

// Scoreboard depth, equal to the credits the decoder starts with
`define NR_SB_ENTRIES 4
// Scoreboard index width, 2**TRANS_ID_BITS must equal NR_SB_ENTRIES
`define TRANS_ID_BITS 2
// Cycles from ALU request to writeback
`define ALU_LATENCY 2

`endif

//--- rtl/isa_pkg.sv
`include "issue_macros.svh"

package isa_pkg;

  // ----------------------------------------------------------
  // Opcodes
  // ----------------------------------------------------------

  // Integer ALU operations, the only class of instruction here
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  // ----------------------------------------------------------
  // Decoder output
  // ----------------------------------------------------------

  typedef struct packed {
    alu_op_e          op;
    // Destination and source register indices
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    // Take the second operand from imm instead of rs2
    logic             use_imm;
    logic [`XLEN-1:0] imm;
  } decoded_instr_t;

endpackage

//--- rtl/issue_pkg.sv
`include "issue_macros.svh"

package issue_pkg;

  // ----------------------------------------------------------
  // Scoreboard records
  // ----------------------------------------------------------

  // One in-flight instruction
  typedef struct packed {
    isa_pkg::decoded_instr_t instr;
    // Already sent to the ALU
    logic                    issued;
    // Result field holds the final value
    logic                    res_valid;
    logic [`XLEN-1:0]        result;
  } sb_entry_t;

  // Scoreboard state seen by the operand read logic
  typedef struct packed {
    sb_entry_t [`NR_SB_ENTRIES-1:0] sbe;
    // Slot occupied and not yet committed
    logic [`NR_SB_ENTRIES-1:0]      still_valid;
    logic [`TRANS_ID_BITS-1:0]      issue_pointer;
    logic [`TRANS_ID_BITS-1:0]      commit_pointer;
  } forwarding_t;

  // ----------------------------------------------------------
  // Execute and retire records
  // ----------------------------------------------------------

  // Request into the ALU pipeline
  typedef struct packed {
    logic                      valid;
    isa_pkg::alu_op_e          op;
    logic [`XLEN-1:0]          operand_a;
    logic [`XLEN-1:0]          operand_b;
    logic [`TRANS_ID_BITS-1:0] trans_id;
  } alu_req_t;

  // ALU result tagged with its scoreboard slot
  typedef struct packed {
    logic                      valid;
    logic [`TRANS_ID_BITS-1:0] trans_id;
    logic [`XLEN-1:0]          result;
  } wb_t;

  // Retired instruction, also the register file write port
  typedef struct packed {
    logic                      valid;
    logic [`TRANS_ID_BITS-1:0] trans_id;
    logic [4:0]                rd;
    logic [`XLEN-1:0]          data;
  } commit_t;

endpackage

//--- rtl/regfile_ff.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module regfile_ff (
  input  logic             clk_i,
  input  logic             reset_i,
  // Two read ports
  input  logic [4:0]       raddr_a_i,
  input  logic [4:0]       raddr_b_i,
  output logic [`XLEN-1:0] rdata_a_o,
  output logic [`XLEN-1:0] rdata_b_o,
  // Single write port
  input  logic             we_i,
  input  logic [4:0]       waddr_i,
  input  logic [`XLEN-1:0] wdata_i
);

  logic [`NR_REGS-1:0][`XLEN-1:0] regs_q;
  // Writes to register 0 are dropped
  logic                           wr_en;

  // Zero for register 0, otherwise a same-cycle write wins over the array
  function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
    logic [`XLEN-1:0] data;
    data = regs_q[addr];
    if (addr == 5'd0) begin
      data = '0;
    end else if (wr_en && (waddr_i == addr)) begin
      data = wdata_i;
    end
    return data;
  endfunction

  assign wr_en = we_i & (waddr_i != 5'd0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  always_comb begin
    rdata_a_o = read_port(raddr_a_i);
    rdata_b_o = read_port(raddr_b_i);
  end

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module alu_unit (
  input  logic                clk_i,
  input  logic                reset_i,
  input  issue_pkg::alu_req_t req_i,
  output issue_pkg::wb_t      wb_o
);

  import isa_pkg::*;
  import issue_pkg::*;

  logic [`XLEN-1:0]       result;
  // One stage per cycle of latency, a new request may enter every cycle
  wb_t [`ALU_LATENCY-1:0] pipe_q;

  // ----------------------------------------------------------
  // Result computation
  // ----------------------------------------------------------

  always_comb begin
    case (req_i.op)
      ALU_ADD: result = req_i.operand_a + req_i.operand_b;
      ALU_SUB: result = req_i.operand_a - req_i.operand_b;
      ALU_AND: result = req_i.operand_a & req_i.operand_b;
      ALU_OR:  result = req_i.operand_a | req_i.operand_b;
      ALU_XOR: result = req_i.operand_a ^ req_i.operand_b;
      // Shift amount from the low 5 bits only
      ALU_SLL: result = req_i.operand_a << req_i.operand_b[4:0];
      ALU_SRL: result = req_i.operand_a >> req_i.operand_b[4:0];
      // Signed less-than, 1 or 0
      ALU_SLT: result = `XLEN'($signed(req_i.operand_a) < $signed(req_i.operand_b));
      default: result = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Latency pipeline
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `ALU_LATENCY; i++) begin
        pipe_q[i].valid <= 1'b0;
      end
    end else begin
      pipe_q[0].valid    <= req_i.valid;
      pipe_q[0].trans_id <= req_i.trans_id;
      pipe_q[0].result   <= result;
      for (int i = 1; i < `ALU_LATENCY; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  // Last stage is the writeback to the scoreboard
  assign wb_o = pipe_q[`ALU_LATENCY-1];

endmodule

//--- rtl/scoreboard.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module scoreboard (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Decoder side, guarded by credits
  input  logic                      instr_valid_i,
  input  isa_pkg::decoded_instr_t   instr_i,
  // Oldest unissued entry towards issue
  output issue_pkg::sb_entry_t      issue_entry_o,
  output logic                      issue_valid_o,
  output logic [`TRANS_ID_BITS-1:0] issue_id_o,
  input  logic                      issue_ack_i,
  // ALU writeback
  input  issue_pkg::wb_t            wb_i,
  // Whole buffer for operand forwarding
  output issue_pkg::forwarding_t    fwd_o,
  // In-order retirement
  output issue_pkg::commit_t        commit_o,
  output logic                      credit_o
);

  import issue_pkg::*;

  // Entry storage and per-slot occupancy
  sb_entry_t [`NR_SB_ENTRIES-1:0] sbe_q;
  logic [`NR_SB_ENTRIES-1:0]      entry_valid_q;

  // Insert, issue and commit pointers, all wrap at the buffer depth
  logic [`TRANS_ID_BITS-1:0]      tail_ptr_q;
  logic [`TRANS_ID_BITS-1:0]      issue_ptr_q;
  logic [`TRANS_ID_BITS-1:0]      commit_ptr_q;

  // Head holds its final result
  logic                           commit_ready;

  // ----------------------------------------------------------
  // Issue and forwarding views
  // ----------------------------------------------------------

  assign issue_entry_o = sbe_q[issue_ptr_q];
  // Slot under the issue pointer may be full but already issued
  assign issue_valid_o = entry_valid_q[issue_ptr_q] & ~sbe_q[issue_ptr_q].issued;
  assign issue_id_o    = issue_ptr_q;

  assign fwd_o.sbe            = sbe_q;
  assign fwd_o.still_valid    = entry_valid_q;
  assign fwd_o.issue_pointer  = issue_ptr_q;
  assign fwd_o.commit_pointer = commit_ptr_q;

  assign commit_ready = entry_valid_q[commit_ptr_q] & sbe_q[commit_ptr_q].res_valid;

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tail_ptr_q    <= '0;
      issue_ptr_q   <= '0;
      commit_ptr_q  <= '0;
      entry_valid_q <= '0;
    end else begin
      // Retire head and free its slot
      if (commit_ready) begin
        entry_valid_q[commit_ptr_q] <= 1'b0;
        commit_ptr_q                <= commit_ptr_q + 1'b1;
      end
      // Credits guarantee the tail slot is free here
      if (instr_valid_i) begin
        entry_valid_q[tail_ptr_q] <= 1'b1;
        tail_ptr_q                <= tail_ptr_q + 1'b1;
      end
      if (issue_ack_i) begin
        issue_ptr_q <= issue_ptr_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Entry contents
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NR_SB_ENTRIES; i++) begin
        sbe_q[i].issued    <= 1'b0;
        sbe_q[i].res_valid <= 1'b0;
      end
    end else begin
      if (issue_ack_i) begin
        sbe_q[issue_ptr_q].issued <= 1'b1;
      end
      // Result lands in the slot named by the tag
      if (wb_i.valid) begin
        sbe_q[wb_i.trans_id].res_valid <= 1'b1;
        sbe_q[wb_i.trans_id].result    <= wb_i.result;
      end
      // New instruction starts unissued with no result
      if (instr_valid_i) begin
        sbe_q[tail_ptr_q].instr     <= instr_i;
        sbe_q[tail_ptr_q].issued    <= 1'b0;
        sbe_q[tail_ptr_q].res_valid <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Commit port
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      commit_o.valid <= 1'b0;
    end else begin
      commit_o.valid <= commit_ready;
      if (commit_ready) begin
        commit_o.trans_id <= commit_ptr_q;
        commit_o.rd       <= sbe_q[commit_ptr_q].instr.rd;
        commit_o.data     <= sbe_q[commit_ptr_q].result;
      end
    end
  end

  // One credit back to the decoder per retired instruction
  assign credit_o = commit_o.valid;

endmodule

//--- rtl/issue_read_operands.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_read_operands (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Candidate from the scoreboard
  input  issue_pkg::sb_entry_t      issue_entry_i,
  input  logic                      issue_valid_i,
  input  logic [`TRANS_ID_BITS-1:0] issue_id_i,
  output logic                      issue_ack_o,
  // In-flight results
  input  issue_pkg::forwarding_t    fwd_i,
  // Retired result, writes the register file
  input  issue_pkg::commit_t        commit_i,
  // Registered ALU request
  output issue_pkg::alu_req_t       alu_req_o
);

  import issue_pkg::*;

  // Outcome of the search for one source register
  typedef struct packed {
    logic             hit;
    logic             ready;
    logic [`XLEN-1:0] data;
  } fwd_lookup_t;

  logic [`XLEN-1:0]          rf_rdata_a;
  logic [`XLEN-1:0]          rf_rdata_b;
  // Number of entries older than the candidate
  logic [`TRANS_ID_BITS-1:0] older_cnt;
  fwd_lookup_t               lookup_a;
  fwd_lookup_t               lookup_b;
  logic                      stall_a;
  logic                      stall_b;
  logic [`XLEN-1:0]          operand_a;
  logic [`XLEN-1:0]          operand_b;

  // Walk from oldest to youngest so the last match is the youngest writer
  // Register 0 never matches, its value is constant
  function automatic fwd_lookup_t find_writer(input forwarding_t fwd,
                                              input logic [`TRANS_ID_BITS-1:0] older,
                                              input logic [4:0] rs);
    fwd_lookup_t               res;
    logic [`TRANS_ID_BITS-1:0] idx;
    res = '0;
    for (int i = 0; i < `NR_SB_ENTRIES; i++) begin
      idx = fwd.commit_pointer + `TRANS_ID_BITS'(i);
      if ((`TRANS_ID_BITS'(i) < older) && fwd.still_valid[idx] &&
          (rs != 5'd0) && (fwd.sbe[idx].instr.rd == rs)) begin
        res.hit   = 1'b1;
        res.ready = fwd.sbe[idx].res_valid;
        res.data  = fwd.sbe[idx].result;
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Register file, written at commit
  // ----------------------------------------------------------

  regfile_ff i_regfile_ff (
    .clk_i,
    .reset_i,
    .raddr_a_i (issue_entry_i.instr.rs1),
    .raddr_b_i (issue_entry_i.instr.rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (commit_i.valid),
    .waddr_i   (commit_i.rd),
    .wdata_i   (commit_i.data)
  );

  // ----------------------------------------------------------
  // Hazard check and operand select
  // ----------------------------------------------------------

  assign older_cnt = fwd_i.issue_pointer - fwd_i.commit_pointer;

  always_comb begin
    lookup_a = find_writer(fwd_i, older_cnt, issue_entry_i.instr.rs1);
    lookup_b = find_writer(fwd_i, older_cnt, issue_entry_i.instr.rs2);
    // RAW hazard: older writer still waiting for its result
    stall_a = lookup_a.hit & ~lookup_a.ready;
    // rs2 is no source when the immediate is used
    stall_b = ~issue_entry_i.instr.use_imm & lookup_b.hit & ~lookup_b.ready;
    operand_a = lookup_a.hit ? lookup_a.data : rf_rdata_a;
    if (issue_entry_i.instr.use_imm) begin
      operand_b = issue_entry_i.instr.imm;
    end else if (lookup_b.hit) begin
      operand_b = lookup_b.data;
    end else begin
      operand_b = rf_rdata_b;
    end
  end

  assign issue_ack_o = issue_valid_i & ~(stall_a | stall_b);

  // ----------------------------------------------------------
  // ALU request register
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alu_req_o.valid <= 1'b0;
    end else begin
      alu_req_o.valid <= issue_ack_o;
      if (issue_ack_o) begin
        alu_req_o.op        <= issue_entry_i.instr.op;
        alu_req_o.operand_a <= operand_a;
        alu_req_o.operand_b <= operand_b;
        alu_req_o.trans_id  <= issue_id_i;
      end
    end
  end

endmodule

//--- rtl/issue_stage.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_stage (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Decoder
  input  logic                    instr_valid_i,
  input  isa_pkg::decoded_instr_t instr_i,
  output logic                    credit_o,
  // Retirement
  output issue_pkg::commit_t      commit_o,
  // ALU
  output issue_pkg::alu_req_t     alu_req_o,
  input  issue_pkg::wb_t          wb_i
);

  import issue_pkg::*;

  // ----------------------------------------------------------
  // Scoreboard <-> issue and read operands
  // ----------------------------------------------------------

  forwarding_t               fwd;
  sb_entry_t                 issue_entry_sb_iro;
  logic                      issue_valid_sb_iro;
  logic [`TRANS_ID_BITS-1:0] issue_id_sb_iro;
  logic                      issue_ack_iro_sb;
  // Retired result, also feeds the register file write port
  commit_t                   commit_sb_iro;

  assign commit_o = commit_sb_iro;

  // In-flight instruction tracking
  scoreboard i_scoreboard (
    .clk_i,
    .reset_i,
    .instr_valid_i,
    .instr_i,
    .issue_entry_o (issue_entry_sb_iro),
    .issue_valid_o (issue_valid_sb_iro),
    .issue_id_o    (issue_id_sb_iro),
    .issue_ack_i   (issue_ack_iro_sb),
    .wb_i,
    .fwd_o         (fwd),
    .commit_o      (commit_sb_iro),
    .credit_o
  );

  // Operand fetch, hazard stall and dispatch
  issue_read_operands i_issue_read_operands (
    .clk_i,
    .reset_i,
    .issue_entry_i (issue_entry_sb_iro),
    .issue_valid_i (issue_valid_sb_iro),
    .issue_id_i    (issue_id_sb_iro),
    .issue_ack_o   (issue_ack_iro_sb),
    .fwd_i         (fwd),
    .commit_i      (commit_sb_iro),
    .alu_req_o
  );

endmodule

//--- rtl/issue_core.sv
`timescale 1ns/1ps

module issue_core (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Decoder, credit based
  input  logic                    instr_valid_i,
  input  isa_pkg::decoded_instr_t instr_i,
  output logic                    credit_o,
  // One retired instruction per cycle at most
  output issue_pkg::commit_t      commit_o
);

  import issue_pkg::*;

  // ----------------------------------------------------------
  // Issue stage <-> ALU
  // ----------------------------------------------------------

  // ALU is fully pipelined, so requests need no ready
  alu_req_t alu_req;
  wb_t      wb;

  issue_stage i_issue_stage (
    .clk_i,
    .reset_i,
    .instr_valid_i,
    .instr_i,
    .credit_o,
    .commit_o,
    .alu_req_o (alu_req),
    .wb_i      (wb)
  );

  alu_unit i_alu_unit (
    .clk_i,
    .reset_i,
    .req_i (alu_req),
    .wb_o  (wb)
  );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Synchronous reset held over the first 3 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

//--- tests/tb_issue_core.sv
`timescale 1ns/1ps
`include "issue_macros.svh"

module tb_issue_core;

  import isa_pkg::*;
  import issue_pkg::*;

  // Instruction counts per test, used for the timeout
  localparam int NR_FILL    = 15;
  localparam int NR_OPS     = 16;
  localparam int NR_CHAIN   = 24;
  localparam int NR_ZERO    = 8;
  localparam int NR_BURST   = 48;
  localparam int NR_RANDOM  = 300;
  localparam int NR_INSTR   = NR_FILL + NR_OPS + NR_CHAIN + NR_ZERO + NR_BURST + NR_RANDOM;
  localparam int TIMEOUT_CYCLES =
    NR_INSTR * (`NR_SB_ENTRIES + `ALU_LATENCY + 6) + 100;

  logic                      clk;
  logic                      reset;
  logic                      instr_valid;
  decoded_instr_t            instr;
  logic                      credit;
  commit_t                   commit;

  // Reference state, updated in program order at send time
  logic [`XLEN-1:0]          model_rf [`NR_REGS];
  commit_t                   exp_q [$];
  logic [`TRANS_ID_BITS-1:0] next_tid;
  // Decoder view of the credits
  int                        credits;
  int                        credit_pulses;
  int                        sent_cnt;
  int                        cycle_cnt;
  integer                    seed;
  string                     test_name;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  issue_core u_issue_core (
    .clk_i         (clk),
    .reset_i       (reset),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .credit_o      (credit),
    .commit_o      (commit)
  );

  // ----------------------------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------------------------

  // Expected ALU result from the opcode definitions
  function automatic logic [`XLEN-1:0] ref_alu(input alu_op_e op,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] res;
    case (op)
      ALU_ADD: res = a + b;
      ALU_SUB: res = a - b;
      ALU_AND: res = a & b;
      ALU_OR:  res = a | b;
      ALU_XOR: res = a ^ b;
      // Only the low 5 bits shift
      ALU_SLL: res = a << b[4:0];
      ALU_SRL: res = a >> b[4:0];
      ALU_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_commit(input string name, input commit_t exp, input commit_t act);
    if (exp !== act) begin
      abort_run($sformatf({"CHECK FAILED %s: expected tid %0d rd %0d data 0x%08h,",
                           " actual tid %0d rd %0d data 0x%08h"},
                          name, exp.trans_id, exp.rd, exp.data,
                          act.trans_id, act.rd, act.data));
    end
  endtask

  task automatic check_credits(input string name, input int exp, input int act);
    if (exp != act) begin
      abort_run($sformatf("CHECK FAILED %s: expected credits %0d, actual %0d",
                          name, exp, act));
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------

  function automatic decoded_instr_t make_instr(input alu_op_e op, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2,
                                                input logic use_imm,
                                                input logic [`XLEN-1:0] imm);
    decoded_instr_t ins;
    ins.op      = op;
    ins.rd      = rd;
    ins.rs1     = rs1;
    ins.rs2     = rs2;
    ins.use_imm = use_imm;
    ins.imm     = imm;
    return ins;
  endfunction

  // Any register, register 0 included
  function automatic decoded_instr_t rand_instr();
    decoded_instr_t ins;
    ins.op      = alu_op_e'($random(seed) & 7);
    ins.rd      = 5'($random(seed));
    ins.rs1     = 5'($random(seed));
    ins.rs2     = 5'($random(seed));
    ins.use_imm = 1'($random(seed));
    ins.imm     = $random(seed);
    return ins;
  endfunction

  // Called at a falling edge, returns at the next one
  task automatic send_instr(input decoded_instr_t ins);
    logic [`XLEN-1:0] op_b;
    commit_t          exp;
    // Hold off until the decoder owns a credit
    while (credits == 0) begin
      @(negedge clk);
    end
    instr_valid = 1'b1;
    instr       = ins;
    op_b = ins.use_imm ? ins.imm : model_rf[ins.rs2];
    exp.valid    = 1'b1;
    exp.trans_id = next_tid;
    exp.rd       = ins.rd;
    exp.data     = ref_alu(ins.op, model_rf[ins.rs1], op_b);
    // Register 0 keeps reading zero
    if (ins.rd != 5'd0) begin
      model_rf[ins.rd] = exp.data;
    end
    exp_q.push_back(exp);
    next_tid = next_tid + 1'b1;
    credits--;
    sent_cnt++;
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  // Wait for every expected commit, then all credits must be home
  task automatic drain_pipeline();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    check_credits(test_name, `NR_SB_ENTRIES, credits);
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------

  // Loads r1..r15 with random values through r0 + imm
  task automatic fill_regs();
    test_name = "fill_regs";
    for (int r = 1; r <= NR_FILL; r++) begin
      send_instr(make_instr(ALU_ADD, 5'(r), 5'd0, 5'd0, 1'b1, $random(seed)));
    end
    drain_pipeline();
  endtask

  // Sources in r1..r15, destinations in r16..r31
  task automatic sweep_ops();
    test_name = "all_ops";
    for (int op = 0; op < 8; op++) begin
      for (int u = 0; u < 2; u++) begin
        send_instr(make_instr(alu_op_e'(op), 5'(16 + 2 * op + u), 5'(1 + op),
                              5'(8 + op), u[0], $random(seed)));
      end
    end
    drain_pipeline();
  endtask

  // Each instruction reads the rd of the one before
  task automatic chain_deps();
    logic [4:0] prev_rd;
    logic [4:0] rd;
    test_name = "dep_chains";
    prev_rd = 5'd20;
    for (int k = 0; k < NR_CHAIN; k++) begin
      rd = 5'(20 + (k + 1) % 4);
      send_instr(make_instr(alu_op_e'(k % 8), rd, prev_rd,
                            (k % 2 == 1) ? prev_rd : 5'(1 + k % 15),
                            (k % 3 == 0), $random(seed)));
      prev_rd = rd;
    end
    drain_pipeline();
  endtask

  // Writers of r0 in flight while readers of r0 issue
  task automatic zero_reg_access();
    test_name = "zero_reg";
    send_instr(make_instr(ALU_ADD, 5'd0, 5'd1, 5'd0, 1'b1, 32'h55));
    send_instr(make_instr(ALU_ADD, 5'd9, 5'd0, 5'd0, 1'b0, 32'h0));
    send_instr(make_instr(ALU_OR, 5'd10, 5'd0, 5'd0, 1'b1, 32'h1234));
    send_instr(make_instr(ALU_XOR, 5'd0, 5'd2, 5'd3, 1'b0, 32'h0));
    send_instr(make_instr(ALU_SUB, 5'd11, 5'd0, 5'd0, 1'b0, 32'h0));
    send_instr(make_instr(ALU_ADD, 5'd12, 5'd0, 5'd1, 1'b0, 32'h0));
    send_instr(make_instr(ALU_SLL, 5'd0, 5'd12, 5'd0, 1'b1, 32'h3));
    send_instr(make_instr(ALU_OR, 5'd13, 5'd0, 5'd0, 1'b0, 32'h0));
    drain_pipeline();
  endtask

  // Bursts longer than the scoreboard, so sends wait for credits
  task automatic credit_bursts();
    test_name = "bursts";
    for (int b = 0; b < NR_BURST / 6; b++) begin
      for (int k = 0; k < 6; k++) begin
        send_instr(rand_instr());
      end
      drain_pipeline();
    end
  endtask

  task automatic random_mix();
    int gap;
    test_name = "random_mix";
    for (int k = 0; k < NR_RANDOM; k++) begin
      send_instr(rand_instr());
      // Idle cycles between 0 and 3
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
    end
    drain_pipeline();
  endtask

  // ----------------------------------------------------------
  // Commit and credit monitor
  // ----------------------------------------------------------

  // Outputs are registered, so the value before the edge is the cycle's value
  always @(posedge clk) begin
    if (!reset) begin
      if (credit) begin
        credits++;
        credit_pulses++;
        if (credits > `NR_SB_ENTRIES) begin
          abort_run("decoder credit count rose above the scoreboard depth");
        end
      end
      if (commit.valid) begin
        if (exp_q.size() == 0) begin
          abort_run("commit seen with no instruction outstanding");
        end else begin
          check_commit(test_name, exp_q.pop_front(), commit);
        end
      end
      // Credit returns in the commit cycle, so held plus in flight is the depth
      check_credits(test_name, `NR_SB_ENTRIES - exp_q.size(), credits);
    end
  end

  // Run length limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles in test %s", cycle_cnt, test_name));
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    instr_valid   = 1'b0;
    instr         = '0;
    next_tid      = '0;
    credits       = `NR_SB_ENTRIES;
    credit_pulses = 0;
    sent_cnt      = 0;
    cycle_cnt     = 0;
    seed          = 14;
    test_name     = "reset";
    for (int r = 0; r < `NR_REGS; r++) begin
      model_rf[r] = '0;
    end
    @(negedge clk);
    while (reset !== 1'b0) begin
      @(negedge clk);
    end
    if ((credit !== 1'b0) || (commit.valid !== 1'b0)) begin
      abort_run("commit or credit output not idle after reset");
    end
    fill_regs();
    sweep_ops();
    chain_deps();
    zero_reg_access();
    credit_bursts();
    random_mix();
    // One credit back per instruction sent
    check_credits("credit_pulses", sent_cnt, credit_pulses);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/regfile_ff.sv
rtl/alu_unit.sv
rtl/scoreboard.sv
rtl/issue_read_operands.sv
rtl/issue_stage.sv
rtl/issue_core.sv
tests/tb_clock_gen.sv
tests/tb_issue_core.sv

//--- Bender.yml
package:
  name: issue_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/issue_pkg.sv
      - rtl/regfile_ff.sv
      - rtl/alu_unit.sv
      - rtl/scoreboard.sv
      - rtl/issue_read_operands.sv
      - rtl/issue_stage.sv
      - rtl/issue_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_issue_core.sv
